// ==== project.f ====
source/rx_const_pkg.sv
source/prbs_pkg.sv
source/rx_bit_select.sv
source/prbs_bist_gen.sv
source/prbs_lane_checker.sv
source/prbs_stat_counter.sv
source/rx_bist_top.sv
sim/tb_clock_gen.sv
sim/rx_bist_checker.sv
sim/tb_rx_bist_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_rx_bist_top \
    -f project.f \
    -o sim_rx_bist

# a $fatal in the run gives a nonzero exit status
./obj_dir/sim_rx_bist

// ==== sim/rx_bist_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_bist_checker
    import rx_const_pkg::*;
(
    input wire logic       clk_adc,
    input wire logic       cdr_rstb,
    input wire logic       ctl_valid_i,
    input wire logic       rd_req_i,
    input wire logic       rd_ack_i,
    input wire bit_count_t err_count_i,
    input wire bit_count_t total_count_i
);

    // assertion failures so far, polled by the testbench
    int unsigned fail_cnt;
    // rising edges since reset release, parks at WAIT_CYCLES
    int unsigned rel_edges;

    initial fail_cnt = 0;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rel_edges <= 0;
        end else if (rel_edges < WAIT_CYCLES) begin
            rel_edges <= rel_edges + 1;
        end
    end

    ////////////////////////////////////////
    // reset and valid timing
    ////////////////////////////////////////

    a_reset_state: assert property (@(posedge clk_adc)
        !cdr_rstb && $past(!cdr_rstb) |-> !ctl_valid_i && !rd_ack_i
            && err_count_i == '0 && total_count_i == '0)
        else begin
            fail_cnt++;
            $error("outputs not cleared while reset is held");
        end

    // high exactly from the 32nd edge after release
    a_valid_edge: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_i == (rel_edges == WAIT_CYCLES))
        else begin
            fail_cnt++;
            $error("ctl_valid_o does not follow the reset wait");
        end

    a_valid_holds: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_i |=> ctl_valid_i)
        else begin
            fail_cnt++;
            $error("ctl_valid_o dropped without a reset");
        end

    ////////////////////////////////////////
    // snapshot handshake
    ////////////////////////////////////////

    a_ack_rise: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $rose(rd_ack_i) |-> $past(rd_req_i) && rd_req_i)
        else begin
            fail_cnt++;
            $error("rd_ack_o rose without a pending request");
        end

    a_ack_fall: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        $fell(rd_ack_i) |-> !$past(rd_req_i))
        else begin
            fail_cnt++;
            $error("rd_ack_o fell while rd_req_i was still high");
        end

    a_snap_stable: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        rd_ack_i && $past(rd_ack_i) |-> $stable(err_count_i) && $stable(total_count_i))
        else begin
            fail_cnt++;
            $error("snapshot outputs changed while rd_ack_o was high");
        end

endmodule

bind rx_bist_top rx_bist_checker i_checker (
    .clk_adc       (clk_adc),
    .cdr_rstb      (cdr_rstb),
    .ctl_valid_i   (ctl_valid_o),
    .rd_req_i      (rd_req_i),
    .rd_ack_i      (rd_ack_o),
    .err_count_i   (err_count_o),
    .total_count_i (total_count_o)
);

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_rx_bist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rx_bist_top
    import rx_const_pkg::*;
    import prbs_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 1500;
    localparam int CODE_MAX       = 2 ** (NADC - 1) - 1;
    localparam int CODE_MIN       = -(2 ** (NADC - 1));
    localparam int INJ_COUNT      = 6;

    logic       clk_adc;
    logic       cdr_rstb;
    adc_code_t  adc_code [NTI-1:0];
    adc_code_t  adc_thresh;
    prbs_src_e  src_sel;
    logic       inj_err;
    logic       rd_req;
    wire logic  ctl_valid;
    wire logic  rd_ack;
    bit_count_t err_count;
    bit_count_t total_count;

    // levels applied on the next rising edge
    logic       rstb_level;
    logic       req_level;
    logic       inj_pending;
    logic       tie_pending;
    prbs_src_e  src_mode;
    int         thr;
    integer     seed;
    int         cycle_cnt;
    // reference PRBS7 history, index 0 is 7 bits back
    logic       model_bits [$];

    tb_clock_gen #(.PERIOD_NS(100)) i_clk_gen (.clk_o(clk_adc));

    rx_bist_top i_dut (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_code_i    (adc_code),
        .adc_thresh_i  (adc_thresh),
        .src_sel_i     (src_sel),
        .inj_err_i     (inj_err),
        .rd_req_i      (rd_req),
        .ctl_valid_o   (ctl_valid),
        .rd_ack_o      (rd_ack),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input bit_count_t got, input bit_count_t exp);
        assert (got == exp) else begin
            abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic seed_model();
        int rnd;
        model_bits.delete();
        for (int i = 0; i < NPRBS; i++) begin
            rnd = $random(seed);
            model_bits.push_back(rnd[0]);
        end
        // all zero would lock the sequence
        model_bits[0] = 1'b1;
    endtask

    // four new bits, lane 0 first
    function automatic lane_bits_t next_group();
        lane_bits_t grp;
        for (int i = 0; i < NTI; i++) begin
            grp[i] = model_bits[0] ^ model_bits[1];
            model_bits.push_back(grp[i]);
            void'(model_bits.pop_front());
        end
        return grp;
    endfunction

    // random code on the correct side of the threshold
    function automatic int pick_code(input logic bit_val);
        int unsigned rnd;
        rnd = $random(seed);
        if (bit_val) begin
            return thr + 1 + int'(rnd % unsigned'(CODE_MAX - thr));
        end
        return thr - int'(rnd % unsigned'(thr - CODE_MIN + 1));
    endfunction

    task automatic step();
        lane_bits_t grp;
        int         code;
        @(posedge clk_adc);
        grp = next_group();
        for (int i = 0; i < NTI; i++) begin
            code = pick_code(grp[i]);
            // a code at the threshold slices to 0, one wrong bit
            if (tie_pending && grp[i]) begin
                code = thr;
                tie_pending = 1'b0;
            end
            adc_code[i] <= adc_code_t'(code);
        end
        cdr_rstb    <= rstb_level;
        rd_req      <= req_level;
        inj_err     <= inj_pending;
        src_sel     <= src_mode;
        adc_thresh  <= adc_code_t'(thr);
        inj_pending = 1'b0;
        @(negedge clk_adc);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            step();
        end
    endtask

    task automatic reset_dut(input prbs_src_e mode, input int new_thr);
        src_mode   = mode;
        thr        = new_thr;
        req_level  = 1'b0;
        rstb_level = 1'b0;
        run_cycles(5);
        rstb_level = 1'b1;
        step();
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!ctl_valid) begin
            if (waited > WAIT_CYCLES + 4) begin
                abort_run("ctl_valid_o never rose after reset release");
            end
            step();
            waited++;
        end
    endtask

    // full four-phase read, optionally holding the request
    task automatic read_snapshot(input int hold, output bit_count_t err_val,
                                 output bit_count_t tot_val);
        int waited;
        req_level = 1'b1;
        waited = 0;
        step();
        while (!rd_ack) begin
            if (waited > 8) begin
                abort_run("rd_ack_o did not answer a snapshot request");
            end
            step();
            waited++;
        end
        err_val = err_count;
        tot_val = total_count;
        run_cycles(hold);
        req_level = 1'b0;
        waited = 0;
        step();
        while (rd_ack) begin
            if (waited > 8) begin
                abort_run("rd_ack_o stayed high after the request dropped");
            end
            step();
            waited++;
        end
        step();
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        bit_count_t err_snap;
        bit_count_t tot_snap;
        bit_count_t prev_tot;
        seed        = 32'h05fb_b79a;
        rstb_level  = 1'b0;
        req_level   = 1'b0;
        inj_pending = 1'b0;
        tie_pending = 1'b0;
        src_mode    = SRC_BIST;
        thr         = 0;
        cdr_rstb   <= 1'b0;
        rd_req     <= 1'b0;
        inj_err    <= 1'b0;
        src_sel    <= SRC_BIST;
        adc_thresh <= '0;
        for (int i = 0; i < NTI; i++) begin
            adc_code[i] <= '0;
        end
        seed_model();

        // clean BIST stream, counters grow without errors
        reset_dut(SRC_BIST, 0);
        wait_valid();
        prev_tot = '0;
        for (int s = 0; s < 5; s++) begin
            run_cycles(60);
            read_snapshot((s == 2) ? 6 : 0, err_snap, tot_snap);
            check_value("error count", err_snap, '0);
            assert (tot_snap != 0 && tot_snap % NTI == 0) else begin
                abort_run($sformatf("Mismatch at %0t: total %0d is not a nonzero multiple of %0d",
                                    $time, tot_snap, NTI));
            end
            assert (tot_snap >= prev_tot) else begin
                abort_run($sformatf("Mismatch at %0t: total fell from %0d to %0d",
                                    $time, prev_tot, tot_snap));
            end
            prev_tot = tot_snap;
        end

        // isolated injections, three flags each
        reset_dut(SRC_BIST, 0);
        wait_valid();
        run_cycles(5);
        for (int k = 0; k < INJ_COUNT; k++) begin
            inj_pending = 1'b1;
            run_cycles(4);
        end
        run_cycles(10);
        read_snapshot(0, err_snap, tot_snap);
        check_value("error count", err_snap, bit_count_t'(3 * INJ_COUNT));

        // sliced ADC codes carrying the reference sequence
        reset_dut(SRC_ADC, $random(seed) % 101);
        wait_valid();
        run_cycles(100);
        read_snapshot(0, err_snap, tot_snap);
        check_value("error count", err_snap, '0);

        // same, with one code sitting on the threshold
        reset_dut(SRC_ADC, $random(seed) % 101);
        wait_valid();
        run_cycles(10);
        tie_pending = 1'b1;
        run_cycles(60);
        if (tie_pending) begin
            abort_run("threshold tie was never placed on a 1 bit");
        end
        read_snapshot(0, err_snap, tot_snap);
        check_value("error count", err_snap, bit_count_t'(3));

        if (i_dut.i_checker.fail_cnt != 0) begin
            abort_run("a bound assertion failed during the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // run limit and bound assertion watch
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk_adc);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout after %0d cycles", cycle_cnt));
            end
            if (i_dut.i_checker.fail_cnt != 0) begin
                abort_run("a bound assertion failed");
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/prbs_bist_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_bist_gen
    import rx_const_pkg::*;
    import prbs_pkg::*;
(
    input  wire logic clk_adc,
    input  wire logic cdr_rstb,
    input  wire logic inj_err_i,
    output lane_bits_t bist_bits_o
);

    ////////////////////////////////////////
    // parallel PRBS7
    ////////////////////////////////////////

    prbs_state_t prbs_state;
    prbs_state_t state_next;
    lane_bits_t  group_next;

    // recurrence unrolled NTI times per clock
    // each new bit is pushed in at bit 0 before the next lane is formed
    always_comb begin
        state_next = prbs_state;
        for (int i = 0; i < NTI; i++) begin
            group_next[i] = state_next[PRBS_TAP_A-1] ^ state_next[PRBS_TAP_B-1];
            state_next    = {state_next[NPRBS-2:0], group_next[i]};
        end
    end

    ////////////////////////////////////////
    // state and output registers
    ////////////////////////////////////////

    lane_bits_t inj_mask;

    // error lands on lane 0 only
    assign inj_mask = lane_bits_t'(inj_err_i);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            prbs_state  <= PRBS_SEED;
            bist_bits_o <= '0;
        end else begin
            prbs_state  <= state_next;
            // flip the emitted copy, the sequence keeps running clean
            bist_bits_o <= group_next ^ inj_mask;
        end
    end

endmodule

`default_nettype wire

// ==== source/prbs_lane_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_lane_checker
    import rx_const_pkg::*;
    import prbs_pkg::*;
(
    input  wire logic       clk_adc,
    input  wire logic       cdr_rstb,
    input  wire lane_bits_t rx_bits_i,
    output lane_bits_t      err_flags_o
);

    ////////////////////////////////////////
    // received history
    ////////////////////////////////////////

    // last NPRBS received bits, bit 0 newest
    prbs_state_t rx_hist;
    prbs_state_t hist_next;
    lane_bits_t  err_next;

    // predict every lane from what was actually received,
    // so lane i may use lanes below it in the same group.
    // a single wrong bit therefore shows up three times:
    // at itself and 6 and 7 bits later
    always_comb begin
        hist_next = rx_hist;
        for (int i = 0; i < NTI; i++) begin
            err_next[i] = rx_bits_i[i]
                        ^ hist_next[PRBS_TAP_A-1]
                        ^ hist_next[PRBS_TAP_B-1];
            hist_next   = {hist_next[NPRBS-2:0], rx_bits_i[i]};
        end
    end

    ////////////////////////////////////////
    // flag register
    ////////////////////////////////////////

    // history starts empty and locks after NPRBS received bits,
    // well inside the reset wait of the counters
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rx_hist     <= '0;
            err_flags_o <= '0;
        end else begin
            rx_hist     <= hist_next;
            err_flags_o <= err_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/prbs_pkg.sv ====
`default_nettype none

package prbs_pkg;

    ////////////////////////////////////////
    // PRBS7 definition
    ////////////////////////////////////////

    // x^7 + x^6 + 1
    localparam int NPRBS      = 7;
    // bit n = bit n-6 xor bit n-7
    localparam int PRBS_TAP_A = 6;
    localparam int PRBS_TAP_B = 7;

    // bit 0 is the newest bit, bit NPRBS-1 the oldest
    typedef logic [NPRBS-1:0] prbs_state_t;

    // any nonzero value works
    localparam prbs_state_t PRBS_SEED = '1;

    ////////////////////////////////////////
    // self-test control
    ////////////////////////////////////////

    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

    // snapshot readout handshake
    typedef enum logic [1:0] {
        RD_IDLE     = 2'd0,
        RD_ACK      = 2'd1,
        RD_WAIT_LOW = 2'd2
    } rd_state_e;

endpackage

`default_nettype wire

// ==== source/prbs_stat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_stat_counter
    import rx_const_pkg::*;
    import prbs_pkg::*;
(
    input  wire logic       clk_adc,
    input  wire logic       cdr_rstb,
    input  wire lane_bits_t err_flags_i,
    input  wire logic       rd_req_i,
    output logic            ctl_valid_o,
    output logic            rd_ack_o,
    output bit_count_t      err_count_o,
    output bit_count_t      total_count_o
);

    ////////////////////////////////////////
    // reset wait
    ////////////////////////////////////////

    wait_cnt_t wait_cnt;

    // counts edges since release and parks at WAIT_CYCLES
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt <= '0;
        end else if (wait_cnt != wait_cnt_t'(WAIT_CYCLES)) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // high from the 32nd edge on
    assign ctl_valid_o = (wait_cnt == wait_cnt_t'(WAIT_CYCLES));

    ////////////////////////////////////////
    // error and total counters
    ////////////////////////////////////////

    lane_sum_t  err_sum;
    bit_count_t err_cnt;
    bit_count_t total_cnt;

    // number of flagged lanes this cycle
    always_comb begin
        err_sum = '0;
        for (int i = 0; i < NTI; i++) begin
            err_sum = err_sum + lane_sum_t'(err_flags_i[i]);
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_cnt   <= '0;
            total_cnt <= '0;
        end else if (ctl_valid_o) begin
            err_cnt   <= err_cnt + bit_count_t'(err_sum);
            total_cnt <= total_cnt + bit_count_t'(NTI);
        end
    end

    ////////////////////////////////////////
    // snapshot readout
    ////////////////////////////////////////

    rd_state_e rd_state;

    // counters keep running, only the snapshot holds while acked
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rd_state      <= RD_IDLE;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_req_i) begin
                        err_count_o   <= err_cnt;
                        total_count_o <= total_cnt;
                        rd_state      <= RD_ACK;
                    end
                end
                RD_ACK: begin
                    if (!rd_req_i) begin
                        rd_state <= RD_WAIT_LOW;
                    end
                end
                // ack is low here, next request waits one more cycle
                RD_WAIT_LOW: begin
                    if (!rd_req_i) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    assign rd_ack_o = (rd_state == RD_ACK);

endmodule

`default_nettype wire

// ==== source/rx_bist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_bist_top
    import rx_const_pkg::*;
    import prbs_pkg::*;
(
    input  wire logic      clk_adc,
    input  wire logic      cdr_rstb,
    input  wire adc_code_t adc_code_i [NTI-1:0],
    input  wire adc_code_t adc_thresh_i,
    input  wire prbs_src_e src_sel_i,
    input  wire logic      inj_err_i,
    input  wire logic      rd_req_i,
    output wire logic      ctl_valid_o,
    output wire logic      rd_ack_o,
    output bit_count_t     err_count_o,
    output bit_count_t     total_count_o
);

    ////////////////////////////////////////
    // self-test path
    ////////////////////////////////////////

    wire lane_bits_t bist_bits;
    wire lane_bits_t rx_bits;
    wire lane_bits_t err_flags;

    prbs_bist_gen i_bist_gen (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .inj_err_i   (inj_err_i),
        .bist_bits_o (bist_bits)
    );

    // source to rx_bits, one cycle
    rx_bit_select i_bit_select (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_code_i   (adc_code_i),
        .adc_thresh_i (adc_thresh_i),
        .src_sel_i    (src_sel_i),
        .bist_bits_i  (bist_bits),
        .rx_bits_o    (rx_bits)
    );

    // rx_bits to err_flags, one cycle
    prbs_lane_checker i_lane_checker (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .rx_bits_i   (rx_bits),
        .err_flags_o (err_flags)
    );

    prbs_stat_counter i_stat_counter (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .err_flags_i   (err_flags),
        .rd_req_i      (rd_req_i),
        .ctl_valid_o   (ctl_valid_o),
        .rd_ack_o      (rd_ack_o),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

`default_nettype wire

// ==== source/rx_bit_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_bit_select
    import rx_const_pkg::*;
    import prbs_pkg::*;
(
    input  wire logic      clk_adc,
    input  wire logic      cdr_rstb,
    input  wire adc_code_t adc_code_i [NTI-1:0],
    input  wire adc_code_t adc_thresh_i,
    input  wire prbs_src_e src_sel_i,
    input  wire lane_bits_t bist_bits_i,
    output lane_bits_t     rx_bits_o
);

    ////////////////////////////////////////
    // slicer
    ////////////////////////////////////////

    lane_bits_t adc_bits;

    // signed compare, a code equal to the threshold decides 0
    always_comb begin
        for (int i = 0; i < NTI; i++) begin
            adc_bits[i] = (adc_code_i[i] > adc_thresh_i);
        end
    end

    ////////////////////////////////////////
    // source mux and retiming
    ////////////////////////////////////////

    lane_bits_t sel_bits;

    always_comb begin
        if (src_sel_i == SRC_BIST) begin
            sel_bits = bist_bits_i;
        end else begin
            sel_bits = adc_bits;
        end
    end

    // one cycle from code sample to rx_bits
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rx_bits_o <= '0;
        end else begin
            rx_bits_o <= sel_bits;
        end
    end

endmodule

`default_nettype wire

// ==== source/rx_const_pkg.sv ====
`default_nettype none

package rx_const_pkg;

    ////////////////////////////////////////
    // lane and code geometry
    ////////////////////////////////////////

    // interleaved lanes per clock
    localparam int NTI  = 4;
    // ADC code width, two's complement
    localparam int NADC = 8;
    // statistics counter width
    localparam int NCNT = 32;

    ////////////////////////////////////////
    // reset wait and lane sums
    ////////////////////////////////////////

    // cycles to hold off counting after reset
    localparam int WAIT_CYCLES = 32;
    localparam int WAIT_W      = $clog2(WAIT_CYCLES + 1);
    // holds any count from 0 to NTI
    localparam int LANE_SUM_W  = $clog2(NTI + 1);

    typedef logic signed [NADC-1:0] adc_code_t;
    // lane 0 carries the earliest bit of the cycle
    typedef logic [NTI-1:0]         lane_bits_t;
    typedef logic [NCNT-1:0]        bit_count_t;
    typedef logic [WAIT_W-1:0]      wait_cnt_t;
    typedef logic [LANE_SUM_W-1:0]  lane_sum_t;

endpackage

`default_nettype wire
